// ==== src/rvIsaPkg.sv ====
`default_nettype none

package rvIsaPkg;

  typedef logic [31:0] word_t;    // data, address or instruction
  typedef logic [4:0]  regIdx_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [2:0]  funct3_t;

  localparam word_t RESET_PC = 32'h8000_0000;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // major opcodes
  localparam opcode_t OP_LUI    = 7'b0110111;
  localparam opcode_t OP_AUIPC  = 7'b0010111;
  localparam opcode_t OP_JAL    = 7'b1101111;
  localparam opcode_t OP_JALR   = 7'b1100111;
  localparam opcode_t OP_BRANCH = 7'b1100011;
  localparam opcode_t OP_LOAD   = 7'b0000011;
  localparam opcode_t OP_STORE  = 7'b0100011;
  localparam opcode_t OP_OPIMM  = 7'b0010011;
  localparam opcode_t OP_OP     = 7'b0110011;
  localparam opcode_t OP_SYSTEM = 7'b1110011;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // branch conditions
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  // arithmetic, shared by OP and OP-IMM
  localparam funct3_t F3_ADD  = 3'b000;
  localparam funct3_t F3_SLL  = 3'b001;
  localparam funct3_t F3_SLT  = 3'b010;
  localparam funct3_t F3_SLTU = 3'b011;
  localparam funct3_t F3_XOR  = 3'b100;
  localparam funct3_t F3_SR   = 3'b101;  // srl / sra by bit 30
  localparam funct3_t F3_OR   = 3'b110;
  localparam funct3_t F3_AND  = 3'b111;

  localparam funct3_t F3_W = 3'b010;       // only word loads and stores

  localparam word_t EBREAK_INST = 32'h0010_0073;

endpackage

`default_nettype wire

// ==== src/coreCtrlPkg.sv ====
`default_nettype none

package coreCtrlPkg;

  import rvIsaPkg::*;

  typedef logic [3:0] aluOp_t;
  typedef logic [2:0] immSel_t;
  typedef logic [1:0] wbSel_t;

  localparam aluOp_t ADD   = 4'd0;
  localparam aluOp_t SUB   = 4'd1;
  localparam aluOp_t SLL   = 4'd2;
  localparam aluOp_t SLT   = 4'd3;
  localparam aluOp_t SLTU  = 4'd4;
  localparam aluOp_t XOR   = 4'd5;
  localparam aluOp_t SRL   = 4'd6;
  localparam aluOp_t SRA   = 4'd7;
  localparam aluOp_t OR    = 4'd8;
  localparam aluOp_t AND   = 4'd9;
  localparam aluOp_t PASSB = 4'd10;  // lui

  localparam immSel_t IMM_I = 3'd0;
  localparam immSel_t IMM_S = 3'd1;
  localparam immSel_t IMM_B = 3'd2;
  localparam immSel_t IMM_U = 3'd3;
  localparam immSel_t IMM_J = 3'd4;

  localparam wbSel_t WB_ALU = 2'd0;
  localparam wbSel_t WB_MEM = 2'd1;
  localparam wbSel_t WB_PC4 = 2'd2;

  typedef struct packed {
    logic    regWrite;
    logic    memRead;
    logic    memWrite;
    logic    isBranch;
    logic    isJal;
    logic    isJalr;
    logic    aluASel;   // pc instead of rs1
    logic    aluBSel;   // imm instead of rs2
    aluOp_t  aluOp;
    immSel_t immSel;
    wbSel_t  wbSel;
    funct3_t funct3;
    logic    ebreak;
  } ctrl_t;

endpackage

`default_nettype wire

// ==== src/instDecoder.sv ====
`default_nettype none

module instDecoder
  import rvIsaPkg::*, coreCtrlPkg::*;
(
  input  word_t inst,
  output ctrl_t ctrl
);

  opcode_t opcode;
  funct3_t f3;
  logic    alt;  // bit 30 picks sub / sra

  assign opcode = inst[6:0];
  assign f3     = inst[14:12];
  assign alt    = inst[30];

  function automatic aluOp_t decodeAluOp(input funct3_t fn, input logic altBit,
                                         input logic isRegOp);
    aluOp_t op;
    case (fn)
      F3_ADD:  op = (isRegOp && altBit) ? SUB : ADD;  // no subi
      F3_SLL:  op = SLL;
      F3_SLT:  op = SLT;
      F3_SLTU: op = SLTU;
      F3_XOR:  op = XOR;
      F3_SR:   op = altBit ? SRA : SRL;
      F3_OR:   op = OR;
      F3_AND:  op = AND;
      default: op = ADD;
    endcase
    return op;
  endfunction

  always_comb begin
    ctrl = '0;  // unknown opcode falls through as a no-op
    case (opcode)
      OP_LUI: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluBSel  = 1'b1;
        ctrl.aluOp    = PASSB;
        ctrl.immSel   = IMM_U;
      end
      OP_AUIPC: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluASel  = 1'b1;
        ctrl.aluBSel  = 1'b1;
        ctrl.immSel   = IMM_U;
      end
      OP_JAL: begin
        ctrl.regWrite = 1'b1;
        ctrl.isJal    = 1'b1;
        ctrl.aluASel  = 1'b1;
        ctrl.aluBSel  = 1'b1;
        ctrl.immSel   = IMM_J;
        ctrl.wbSel    = WB_PC4;
      end
      OP_JALR: begin
        ctrl.regWrite = 1'b1;
        ctrl.isJalr   = 1'b1;
        ctrl.aluBSel  = 1'b1;
        ctrl.wbSel    = WB_PC4;
      end
      OP_BRANCH: begin
        ctrl.isBranch = 1'b1;
        ctrl.aluASel  = 1'b1;  // target = pc + imm
        ctrl.aluBSel  = 1'b1;
        ctrl.immSel   = IMM_B;
        ctrl.funct3   = f3;
      end
      OP_LOAD: begin
        if (f3 == F3_W) begin
          ctrl.regWrite = 1'b1;
          ctrl.memRead  = 1'b1;
          ctrl.aluBSel  = 1'b1;
          ctrl.wbSel    = WB_MEM;
        end
      end
      OP_STORE: begin
        if (f3 == F3_W) begin
          ctrl.memWrite = 1'b1;
          ctrl.aluBSel  = 1'b1;
          ctrl.immSel   = IMM_S;
        end
      end
      OP_OPIMM: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluBSel  = 1'b1;
        ctrl.aluOp    = decodeAluOp(f3, alt, 1'b0);
      end
      OP_OP: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluOp    = decodeAluOp(f3, alt, 1'b1);
      end
      OP_SYSTEM: ctrl.ebreak = (inst == EBREAK_INST);
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== src/immGen.sv ====
`default_nettype none

module immGen
  import rvIsaPkg::*, coreCtrlPkg::*;
(
  input  word_t   inst,
  input  immSel_t immSel,
  output word_t   imm
);

  logic sign;

  assign sign = inst[31];

  always_comb begin
    case (immSel)
      IMM_S:   imm = {{20{sign}}, inst[31:25], inst[11:7]};
      IMM_B: begin
        imm = {{19{sign}}, sign, inst[7], inst[30:25], inst[11:8], 1'b0};
      end
      IMM_U:   imm = {inst[31:12], 12'b0};
      IMM_J: begin
        imm = {{11{sign}}, sign, inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      default: imm = {{20{sign}}, inst[31:20]};  // I format
    endcase
  end

endmodule

`default_nettype wire

// ==== src/regFile.sv ====
`default_nettype none

module regFile
  import rvIsaPkg::*;
(
  input  logic    clk,
  input  logic    rstN,
  input  regIdx_t raddr1,
  input  regIdx_t raddr2,
  output word_t   rdata1,
  output word_t   rdata2,
  input  regIdx_t waddr,
  input  word_t   wdata,
  input  logic    wen
);

  word_t regs [32];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != '0) begin  // x0 never written
      regs[waddr] <= wdata;
    end
  end

  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

  // x0 stays zero across every write the core issues
  x0ReadsZero: assert property (@(posedge clk) disable iff (!rstN)
    (raddr1 == '0 |-> rdata1 == '0) and (raddr2 == '0 |-> rdata2 == '0));

endmodule

`default_nettype wire

// ==== src/alu.sv ====
`default_nettype none

module alu
  import rvIsaPkg::*, coreCtrlPkg::*;
(
  input  word_t   a,
  input  word_t   b,
  input  word_t   cmpA,     // rs1
  input  word_t   cmpB,     // rs2
  input  aluOp_t  aluOp,
  input  funct3_t funct3,
  output word_t   result,
  output logic    branchTaken
);

  logic [4:0] shamt;
  logic       eq, lt, ltu;

  assign shamt = b[4:0];

  always_comb begin
    case (aluOp)
      SUB:     result = a - b;
      SLL:     result = a << shamt;
      SLT:     result = {31'b0, $signed(a) < $signed(b)};
      SLTU:    result = {31'b0, a < b};
      XOR:     result = a ^ b;
      SRL:     result = a >> shamt;
      SRA:     result = $signed(a) >>> shamt;
      OR:      result = a | b;
      AND:     result = a & b;
      PASSB:   result = b;
      default: result = a + b;  // ADD, also address and target math
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // branch condition, independent of the adder
  assign eq  = (cmpA == cmpB);
  assign lt  = $signed(cmpA) < $signed(cmpB);
  assign ltu = cmpA < cmpB;

  always_comb begin
    case (funct3)
      F3_BEQ:  branchTaken = eq;
      F3_BNE:  branchTaken = !eq;
      F3_BLT:  branchTaken = lt;
      F3_BGE:  branchTaken = !lt;
      F3_BLTU: branchTaken = ltu;
      F3_BGEU: branchTaken = !ltu;
      default: branchTaken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== src/fetchUnit.sv ====
`default_nettype none

module fetchUnit
  import rvIsaPkg::*, coreCtrlPkg::*;
(
  input  logic  clk,
  input  logic  rstN,
  input  ctrl_t ctrl,
  input  logic  branchTaken,
  input  word_t target,
  output word_t pc,
  output word_t pcPlus4,
  output logic  halted
);

  word_t nextPc;

  assign pcPlus4 = pc + 32'd4;

  always_comb begin
    nextPc = pcPlus4;
    if (halted || ctrl.ebreak) begin
      nextPc = pc;                      // park on the ebreak
    end else if (ctrl.isJalr) begin
      nextPc = {target[31:1], 1'b0};
    end else if (ctrl.isJal || (ctrl.isBranch && branchTaken)) begin
      nextPc = target;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc     <= RESET_PC;
      halted <= 1'b0;
    end else begin
      pc     <= nextPc;
      halted <= halted | ctrl.ebreak;
    end
  end

  // jump and branch targets from the program must stay word aligned
  pcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== src/rvCore.sv ====
`default_nettype none

module rvCore
  import rvIsaPkg::*, coreCtrlPkg::*;
(
  input  logic  clk,
  input  logic  rstN,
  input  word_t inst,
  input  word_t memRData,
  output word_t pc,
  output word_t memAddr,
  output word_t memWData,
  output logic  memWe,
  output logic  memRe,
  output logic  halted
);

  ctrl_t   ctrl;
  regIdx_t rs1, rs2, rd;
  word_t   rdata1, rdata2;
  word_t   imm;
  word_t   aluA, aluB, aluResult;
  word_t   pcPlus4;
  word_t   wbData;
  logic    branchTaken;
  logic    regWe;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // decode
  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];
  assign rd  = inst[11:7];

  instDecoder u_decoder (
    .inst (inst),
    .ctrl (ctrl)
  );

  immGen u_immGen (
    .inst   (inst),
    .immSel (ctrl.immSel),
    .imm    (imm)
  );

  regFile u_regFile (
    .clk    (clk),
    .rstN   (rstN),
    .raddr1 (rs1),
    .raddr2 (rs2),
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .waddr  (rd),
    .wdata  (wbData),
    .wen    (regWe)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // execute
  assign aluA = ctrl.aluASel ? pc  : rdata1;
  assign aluB = ctrl.aluBSel ? imm : rdata2;

  alu u_alu (
    .a           (aluA),
    .b           (aluB),
    .cmpA        (rdata1),
    .cmpB        (rdata2),
    .aluOp       (ctrl.aluOp),
    .funct3      (ctrl.funct3),
    .result      (aluResult),
    .branchTaken (branchTaken)
  );

  fetchUnit u_fetch (
    .clk         (clk),
    .rstN        (rstN),
    .ctrl        (ctrl),
    .branchTaken (branchTaken),
    .target      (aluResult),
    .pc          (pc),
    .pcPlus4     (pcPlus4),
    .halted      (halted)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // memory and write-back
  assign memAddr  = aluResult;
  assign memWData = rdata2;
  assign memWe    = ctrl.memWrite & ~halted & rstN;  // no stray store while in reset
  assign memRe    = ctrl.memRead;

  always_comb begin
    case (ctrl.wbSel)
      WB_MEM:  wbData = memRData;
      WB_PC4:  wbData = pcPlus4;   // link
      default: wbData = aluResult;
    endcase
  end

  assign regWe = ctrl.regWrite & ~halted;

  memStrobesExclusive: assert property (@(posedge clk) disable iff (!rstN)
    !(memWe && memRe));

endmodule

`default_nettype wire

// ==== bench/rvCoreTb.sv ====
`default_nettype none

module rvCoreTb
  import rvIsaPkg::*;
;

  localparam int    CLK_PERIOD   = 40;
  localparam int    RESET_CYCLES = 8;
  localparam int    HOLD_CYCLES  = 10;
  localparam int    DATA_WORDS   = 16;
  localparam word_t DATA_BASE    = 32'h8000_1000;
  localparam word_t NOP_INST     = 32'h0000_0013;  // addi x0, x0, 0
  localparam word_t STORE_INST   = 32'h0000_2023;  // sw x0, 0(x0)

  typedef struct packed {
    word_t addr;
    word_t data;
  } storeRec_t;

  logic  clk;
  logic  rstN;
  word_t inst;
  word_t memRData;
  word_t pc;
  word_t memAddr;
  word_t memWData;
  logic  memWe;
  logic  memRe;
  logic  halted;

  word_t testData [0:255];
  word_t progLen, storeCount, finalPc;
  word_t dataMem [DATA_WORDS];
  int    progBase, recBase;
  int    storesSeen;
  bit    loaded;

  rvCore i_dut (
    .clk      (clk),
    .rstN     (rstN),
    .inst     (inst),
    .memRData (memRData),
    .pc       (pc),
    .memAddr  (memAddr),
    .memWData (memWData),
    .memWe    (memWe),
    .memRe    (memRe),
    .halted   (halted)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checks
  task automatic failNow(input string what);
    $display("%s", what);
    $display("Test failures found");
    $fatal(1, "stopped at first error");
  endtask

  task automatic checkWord(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      failNow($sformatf("[FAIL] %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      failNow($sformatf("[FAIL] %s: got %h, expected %h", name, got, exp));
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // memory models
  task automatic loadTestData();
    $readmemh("bench/rvCore_testdata.hex", testData);
    progLen    = testData[0];
    storeCount = testData[1];
    finalPc    = testData[2];
    if ($isunknown({progLen, storeCount, finalPc}) || progLen > 128) begin
      failNow("test data header is missing or malformed");
    end
    progBase = 3;
    recBase  = progBase + int'(progLen) + DATA_WORDS;
    for (int i = 0; i < DATA_WORDS; i++) begin
      dataMem[i] = testData[progBase + int'(progLen) + i];
    end
    loaded = 1'b1;
  endtask

  function automatic word_t fetchWord(input word_t addr);
    word_t idx;
    idx = (addr - RESET_PC) >> 2;
    if (idx < progLen) begin
      return testData[progBase + int'(idx)];
    end
    return NOP_INST;  // outside the image
  endfunction

  function automatic word_t readData(input word_t addr);
    word_t idx;
    idx = (addr - DATA_BASE) >> 2;
    if (idx < DATA_WORDS) begin
      return dataMem[idx];
    end
    return '0;
  endfunction

  function automatic storeRec_t expectedStore(input int n);
    storeRec_t rec;
    rec.addr = testData[recBase + 2 * n];
    rec.data = testData[recBase + 2 * n + 1];
    return rec;
  endfunction

  // memRData answers once memAddr has settled on the new inst
  task automatic driveAndObserve();
    storeRec_t exp;
    word_t     idx;
    inst = fetchWord(pc);
    #1;
    checkFlag("memRe", memRe, inst[6:0] == OP_LOAD);
    memRData = readData(memAddr);
    #1;
    if (memWe) begin
      if (storesSeen >= int'(storeCount)) begin
        failNow($sformatf("unexpected extra store to address %h", memAddr));
      end
      exp = expectedStore(storesSeen);
      checkWord("memAddr", memAddr, exp.addr);
      checkWord("memWData", memWData, exp.data);
      idx = (memAddr - DATA_BASE) >> 2;
      if (idx < DATA_WORDS) begin
        dataMem[idx] = memWData;
      end
      storesSeen++;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // watchdog sized from the program length
  initial begin
    longint limit;
    wait (loaded);
    limit = (RESET_CYCLES + 4 * longint'(progLen)) * CLK_PERIOD;
    #(limit);
    $display("timeout: the core did not halt within %0d time units", limit);
    $display("Test failures found");
    $fatal(1, "watchdog expired");
  end

  initial begin
    rstN       = 1'b0;
    inst       = STORE_INST;  // reset must hold this store off
    memRData   = '0;
    storesSeen = 0;
    loaded     = 1'b0;
    loadTestData();

    repeat (RESET_CYCLES) begin
      @(negedge clk);
      checkWord("pc", pc, RESET_PC);
      checkFlag("halted", halted, 1'b0);
      checkFlag("memWe", memWe, 1'b0);
    end
    rstN = 1'b1;

    do begin
      driveAndObserve();
      @(negedge clk);
    end while (!halted);

    driveAndObserve();
    checkWord("pc", pc, finalPc);
    repeat (HOLD_CYCLES) begin
      @(negedge clk);
      inst = STORE_INST;  // a halted core must not issue it
      #1;
      checkWord("pc", pc, finalPc);  // parked on ebreak
      checkFlag("halted", halted, 1'b1);
      checkFlag("memWe", memWe, 1'b0);
    end
    checkWord("store count", word_t'(storesSeen), storeCount);

    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/rvCore_testdata.hex ====
// header: program length, store count, final pc; then program, 16 data words
// at 80001000, then store records as address and data
0000002B 0000000D 800000A8
800010B7 // lui   x1, 0x80001
80002137 // lui   x2, 0x80002
0000A183 // lw    x3, 0(x1)
0040A203 // lw    x4, 4(x1)
004182B3 // add   x5, x3, x4
00512023 // sw    x5, 0(x2)
40418333 // sub   x6, x3, x4
00612223 // sw    x6, 4(x2)
4041D393 // srai  x7, x3, 4
00712423 // sw    x7, 8(x2)
00323433 // sltu  x8, x4, x3
00812623 // sw    x8, 12(x2)
003224B3 // slt   x9, x4, x3
00912823 // sw    x9, 16(x2)
FFF1C513 // xori  x10, x3, -1
00A12A23 // sw    x10, 20(x2)
01F21593 // slli  x11, x4, 31
00B12C23 // sw    x11, 24(x2)
00518013 // addi  x0, x3, 5
00012E23 // sw    x0, 28(x2)
00001617 // auipc x12, 1
02C12023 // sw    x12, 32(x2)
00319463 00168693 // bne  x3, x3 (not taken); addi x13, x13, 1
0041C463 01068693 // blt  x3, x4 (taken); skipped addi x13, x13, 16
0041E463 00168693 // bltu x3, x4 (not taken); addi x13, x13, 1
00325463 01068693 // bge  x4, x3 (taken); skipped
00327463 00168693 // bgeu x4, x3 (not taken); addi x13, x13, 1
00318463 01068693 // beq  x3, x3 (taken); skipped
02D12223 // sw    x13, 36(x2)
0080076F // jal   x14, +8
01068693 // skipped
02E12423 // sw    x14, 40(x2)
011707E7 // jalr  x15, 17(x14)
01068693 // skipped
02F12623 // sw    x15, 44(x2)
02D12823 // sw    x13, 48(x2)
00100073 // ebreak
80000010 00000007 12345678 DEADBEEF
0000A5A5 FFFF0000 00000100 7FFFFFFF
11111111 22222222 33333333 44444444
55555555 66666666 77777777 88888888
80002000 80000017  80002004 80000009  80002008 F8000001
8000200C 00000001  80002010 00000000  80002014 7FFFFFEF
80002018 80000000  8000201C 00000000  80002020 80001050
80002024 00000003  80002028 80000090  8000202C 8000009C
80002030 00000003

// ==== sim.f ====
src/rvIsaPkg.sv
src/coreCtrlPkg.sv
src/instDecoder.sv
src/immGen.sv
src/regFile.sv
src/alu.sv
src/fetchUnit.sv
src/rvCore.sv
bench/rvCoreTb.sv
